// ==== axi_rd_pkg.sv ====
`default_nettype none

package axi_rd_pkg;

    // ------------------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------------------
    localparam int ID_W    = 4;
    localparam int ADDR_W  = 16;
    localparam int DATA_W  = 32;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;
    localparam int PAD_W   = DATA_W - ID_W - ADDR_W;    // Zero bits above ID in a beat

    localparam int MAX_BURST_LEN = 8;                   // Beats per request, upper bound

    typedef logic [ID_W-1:0]    id_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;       // {pad, id, beat address}
    typedef logic [LEN_W-1:0]   len_t;        // Beats minus one
    typedef logic [SIZE_W-1:0]  size_t;       // log2 of bytes per beat
    typedef logic [BURST_W-1:0] burst_t;
    typedef logic [RESP_W-1:0]  resp_t;
    typedef logic [3:0]         beat_cnt_t;   // Beat index within a burst

    // Burst type codes
    localparam burst_t BURST_FIXED = 2'd0;
    localparam burst_t BURST_INCR  = 2'd1;
    localparam burst_t BURST_WRAP  = 2'd2;

    // Response codes
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // Simulated faulty ID, errors on its last beat
    localparam id_t ERR_ID = 4'hf;

    // Slot life cycle
    typedef enum logic [1:0] {
        SLOT_IDLE   = 2'd0,   // Free for allocation
        SLOT_ACTIVE = 2'd1,   // Fetching beats
        SLOT_DONE   = 2'd2    // All beats buffered, returning
    } slot_state_t;

endpackage

`default_nettype wire

// ==== burst_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_addr_gen (
    input  wire axi_rd_pkg::addr_t     start_addr,
    input  wire axi_rd_pkg::len_t      len,
    input  wire axi_rd_pkg::size_t     size,
    input  wire axi_rd_pkg::burst_t    burst,
    input  wire axi_rd_pkg::beat_cnt_t beat,
    output axi_rd_pkg::addr_t          addr
);

    // ------------------------------------------------------------------------
    // Common terms
    // ------------------------------------------------------------------------
    axi_rd_pkg::addr_t bytes;      // Bytes per beat
    axi_rd_pkg::addr_t step;       // Offset of this beat from beat 0
    axi_rd_pkg::addr_t aligned;    // Start address aligned to size
    axi_rd_pkg::addr_t win;        // Wrap window size in bytes
    axi_rd_pkg::addr_t win_base;   // Lowest address of the window
    axi_rd_pkg::addr_t win_off;    // Offset inside the window, wrapped

    assign bytes   = axi_rd_pkg::addr_t'(1) << size;
    assign step    = axi_rd_pkg::addr_t'(beat) << size;    // beat * bytes
    assign aligned = start_addr & ~(bytes - 1'b1);

    // Window is a power of two for legal WRAP lengths, so modulo is a mask
    assign win      = (axi_rd_pkg::addr_t'(len) + 1'b1) << size;
    assign win_base = start_addr & ~(win - 1'b1);
    assign win_off  = ((start_addr - win_base) + step) & (win - 1'b1);

    // ------------------------------------------------------------------------
    // Per burst type
    // ------------------------------------------------------------------------
    always_comb begin
        case (burst)
            axi_rd_pkg::BURST_FIXED: begin
                addr = start_addr;                 // Same address every beat
            end
            axi_rd_pkg::BURST_INCR: begin
                // First beat keeps any misalignment, later beats are aligned
                if (beat == '0) begin
                    addr = start_addr;
                end else begin
                    addr = aligned + step;
                end
            end
            axi_rd_pkg::BURST_WRAP: begin
                addr = win_base + win_off;         // Folds back to window base
            end
            default: begin
                addr = start_addr;                 // Reserved code, treat as FIXED
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rr_slot_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_slot_arbiter #(
    parameter int NUM_SLOTS = 4
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [NUM_SLOTS-1:0]         req,     // One bit per slot
    input  wire                          hold,    // Keep current slot while it requests
    output logic [$clog2(NUM_SLOTS)-1:0] ptr,
    output logic                         grant
);

    localparam int PTR_W = $clog2(NUM_SLOTS);

    logic [PTR_W-1:0] ptr_nxt;    // Next requesting slot above ptr
    logic             ptr_move;

    // ------------------------------------------------------------------------
    // Round-robin search
    // ------------------------------------------------------------------------
    // Starts one above ptr and wraps, ptr itself is checked last
    always_comb begin
        int  cand;
        logic found;
        ptr_nxt = ptr;                               // Nothing requesting, stay
        found   = 1'b0;
        for (int k = 1; k <= NUM_SLOTS; k++) begin
            cand = (int'(ptr) + k) % NUM_SLOTS;
            if (!found && req[cand]) begin
                ptr_nxt = PTR_W'(cand);
                found   = 1'b1;
            end
        end
    end

    // Leave the slot when released or when it has nothing to offer
    assign ptr_move = !hold || !req[ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (ptr_move) begin
            ptr <= ptr_nxt;
        end
    end

    assign grant = req[ptr];    // Combinational, follows req at ptr

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    // Non power of two slot counts leave unused codes in ptr
    a_ptr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(ptr) < NUM_SLOTS
    ) else $error("arbiter pointer out of range: %0d", ptr);

endmodule

`default_nettype wire

// ==== rd_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module rd_slot #(
    parameter int FETCH_DLY = 24
) (
    input  wire                       clk,
    input  wire                       rst_n,
    // Request load, one cycle on the AR handshake
    input  wire                       alloc,
    input  wire axi_rd_pkg::id_t      req_id,
    input  wire axi_rd_pkg::addr_t    req_addr,
    input  wire axi_rd_pkg::len_t     req_len,
    input  wire axi_rd_pkg::size_t    req_size,
    input  wire axi_rd_pkg::burst_t   req_burst,
    // Return side
    input  wire                       beat_take,   // R handshake on this slot
    output logic                      free,
    output logic                      beat_ready,
    output logic                      in_burst,
    output axi_rd_pkg::id_t           rid,
    output axi_rd_pkg::data_t         rdata,
    output axi_rd_pkg::resp_t         rresp,
    output logic                      rlast
);

    localparam int BUF_AW = $clog2(axi_rd_pkg::MAX_BURST_LEN);  // Buffer index bits
    localparam int CNT_W  = $clog2(FETCH_DLY + 1);              // Fetch timer bits

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    axi_rd_pkg::slot_state_t state;

    // Captured request
    axi_rd_pkg::id_t    id_r;
    axi_rd_pkg::addr_t  addr_r;
    axi_rd_pkg::len_t   len_r;
    axi_rd_pkg::size_t  size_r;
    axi_rd_pkg::burst_t burst_r;

    logic [CNT_W-1:0]      fetch_cnt;   // Cycles since last fetch
    logic [CNT_W-1:0]      fetch_dly;   // Fetch period for this ID
    logic                  fetch_get;   // Timer expiry, one beat fetched

    axi_rd_pkg::beat_cnt_t fetch_idx;   // Next beat to fetch
    axi_rd_pkg::beat_cnt_t ret_idx;     // Next beat to return
    axi_rd_pkg::beat_cnt_t last_idx;    // Index of the final beat

    logic [axi_rd_pkg::MAX_BURST_LEN-1:0] beat_vld;
    axi_rd_pkg::data_t data_buf [axi_rd_pkg::MAX_BURST_LEN];
    axi_rd_pkg::resp_t resp_buf [axi_rd_pkg::MAX_BURST_LEN];

    axi_rd_pkg::addr_t beat_addr;       // Address of the beat being fetched
    axi_rd_pkg::resp_t beat_resp;

    // Request fields, loaded once per burst
    always_ff @(posedge clk) begin
        if (alloc) begin
            id_r    <= req_id;
            addr_r  <= req_addr;
            len_r   <= req_len;
            size_r  <= req_size;
            burst_r <= req_burst;
        end
    end

    assign last_idx = axi_rd_pkg::beat_cnt_t'(len_r);   // len is below 8 here

    // ------------------------------------------------------------------------
    // Simulated fetch timer
    // ------------------------------------------------------------------------
    // Higher IDs get a shorter period
    assign fetch_dly = CNT_W'(FETCH_DLY) - CNT_W'(id_r);
    assign fetch_get = (state == axi_rd_pkg::SLOT_ACTIVE) && (fetch_cnt == fetch_dly);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_cnt <= '0;
        end else if (alloc || fetch_get) begin
            fetch_cnt <= CNT_W'(1);                  // Restart period
        end else if (state == axi_rd_pkg::SLOT_ACTIVE) begin
            fetch_cnt <= fetch_cnt + 1'b1;
        end
    end

    burst_addr_gen u_burst_addr_gen (
        .start_addr (addr_r),
        .len        (len_r),
        .size       (size_r),
        .burst      (burst_r),
        .beat       (fetch_idx),
        .addr       (beat_addr)
    );

    // Faulty ID fails on the final beat only
    assign beat_resp = ((id_r == axi_rd_pkg::ERR_ID) && (fetch_idx == last_idx))
                     ? axi_rd_pkg::RESP_SLVERR : axi_rd_pkg::RESP_OKAY;

    // Beat buffer, written in fetch order
    always_ff @(posedge clk) begin
        if (fetch_get) begin
            data_buf[fetch_idx[BUF_AW-1:0]] <= {{axi_rd_pkg::PAD_W{1'b0}}, id_r, beat_addr};
            resp_buf[fetch_idx[BUF_AW-1:0]] <= beat_resp;
        end
    end

    // ------------------------------------------------------------------------
    // Slot FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= axi_rd_pkg::SLOT_IDLE;
            fetch_idx <= '0;
            ret_idx   <= '0;
            beat_vld  <= '0;
        end else begin
            case (state)
                axi_rd_pkg::SLOT_IDLE: begin
                    if (alloc) begin
                        state     <= axi_rd_pkg::SLOT_ACTIVE;
                        fetch_idx <= '0;
                        ret_idx   <= '0;
                        beat_vld  <= '0;
                    end
                end
                axi_rd_pkg::SLOT_ACTIVE: begin
                    if (fetch_get) begin
                        beat_vld[fetch_idx[BUF_AW-1:0]] <= 1'b1;
                        fetch_idx <= fetch_idx + 1'b1;
                        if (fetch_idx == last_idx) begin
                            state <= axi_rd_pkg::SLOT_DONE;    // Whole burst buffered
                        end
                    end
                end
                axi_rd_pkg::SLOT_DONE: begin
                    if (beat_take) begin
                        ret_idx <= ret_idx + 1'b1;
                        if (ret_idx == last_idx) begin
                            state    <= axi_rd_pkg::SLOT_IDLE;  // Free again next cycle
                            beat_vld <= '0;
                        end
                    end
                end
                default: begin
                    state <= axi_rd_pkg::SLOT_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Return side
    // ------------------------------------------------------------------------
    // Offered only once every beat is in the buffer, so a started
    // burst never stalls mid-way and never interleaves with another
    assign free       = (state == axi_rd_pkg::SLOT_IDLE);
    assign beat_ready = (state == axi_rd_pkg::SLOT_DONE) && beat_vld[ret_idx[BUF_AW-1:0]];
    assign in_burst   = (state == axi_rd_pkg::SLOT_DONE);    // Owns R channel until rlast

    assign rid   = id_r;
    assign rdata = data_buf[ret_idx[BUF_AW-1:0]];
    assign rresp = beat_ready ? resp_buf[ret_idx[BUF_AW-1:0]] : axi_rd_pkg::RESP_OKAY;
    assign rlast = beat_ready && (ret_idx == last_idx);

    // ------------------------------------------------------------------------
    // Request legality at allocation
    // ------------------------------------------------------------------------
    a_len_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc |-> (int'(req_len) < axi_rd_pkg::MAX_BURST_LEN)
    ) else $error("burst longer than beat buffer, len %0d", req_len);

    a_size_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc |-> (req_size <= 3'd2)
    ) else $error("beat size above data width, size %0d", req_size);

    a_wrap_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        (alloc && (req_burst == axi_rd_pkg::BURST_WRAP)) |->
            ((req_len inside {8'd1, 8'd3, 8'd7}) &&
             ((req_addr & ((axi_rd_pkg::addr_t'(1) << req_size) - 1'b1)) == '0))
    ) else $error("illegal WRAP request, len %0d addr %h", req_len, req_addr);

endmodule

`default_nettype wire

// ==== axi_rd_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rd_slave #(
    parameter int NUM_SLOTS = 4,
    parameter int FETCH_DLY = 24
) (
    input  wire                        clk,
    input  wire                        rst_n,
    // AR channel
    input  wire axi_rd_pkg::id_t       arid,
    input  wire axi_rd_pkg::addr_t     araddr,
    input  wire axi_rd_pkg::len_t      arlen,
    input  wire axi_rd_pkg::size_t     arsize,
    input  wire axi_rd_pkg::burst_t    arburst,
    input  wire                        arvalid,
    output logic                       arready,
    // R channel
    output axi_rd_pkg::id_t            rid,
    output axi_rd_pkg::data_t          rdata,
    output axi_rd_pkg::resp_t          rresp,
    output logic                       rlast,
    output logic                       rvalid,
    input  wire                        rready
);

    localparam int PTR_W = $clog2(NUM_SLOTS);

    logic ar_hs;    // AR handshake
    logic r_hs;     // R handshake

    logic [NUM_SLOTS-1:0] slot_free;
    logic [NUM_SLOTS-1:0] slot_ready;
    logic [NUM_SLOTS-1:0] slot_in_burst;
    logic [NUM_SLOTS-1:0] slot_alloc;
    logic [NUM_SLOTS-1:0] slot_take;
    logic [NUM_SLOTS-1:0] slot_rlast;

    axi_rd_pkg::id_t   slot_rid   [NUM_SLOTS];
    axi_rd_pkg::data_t slot_rdata [NUM_SLOTS];
    axi_rd_pkg::resp_t slot_rresp [NUM_SLOTS];

    logic [PTR_W-1:0] alloc_ptr;    // Slot that takes the next request
    logic [PTR_W-1:0] res_ptr;      // Slot driving the R channel

    assign ar_hs = arvalid & arready;
    assign r_hs  = rvalid & rready;

    // ------------------------------------------------------------------------
    // Slots
    // ------------------------------------------------------------------------
    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
        assign slot_alloc[g] = ar_hs && (alloc_ptr == PTR_W'(g));   // One-hot load
        assign slot_take[g]  = r_hs && (res_ptr == PTR_W'(g));      // One-hot pop

        rd_slot #(
            .FETCH_DLY (FETCH_DLY)
        ) u_rd_slot (
            .clk        (clk),
            .rst_n      (rst_n),
            .alloc      (slot_alloc[g]),
            .req_id     (arid),
            .req_addr   (araddr),
            .req_len    (arlen),
            .req_size   (arsize),
            .req_burst  (arburst),
            .beat_take  (slot_take[g]),
            .free       (slot_free[g]),
            .beat_ready (slot_ready[g]),
            .in_burst   (slot_in_burst[g]),
            .rid        (slot_rid[g]),
            .rdata      (slot_rdata[g]),
            .rresp      (slot_rresp[g]),
            .rlast      (slot_rlast[g])
        );
    end

    // ------------------------------------------------------------------------
    // Arbiters
    // ------------------------------------------------------------------------
    // Pointer steps off the slot as soon as it is taken
    rr_slot_arbiter #(.NUM_SLOTS(NUM_SLOTS)) u_alloc_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (slot_free),
        .hold  (~ar_hs),
        .ptr   (alloc_ptr),
        .grant (arready)       // Low when every slot is busy
    );

    // Selected slot keeps the channel through back-pressure and until rlast
    rr_slot_arbiter #(.NUM_SLOTS(NUM_SLOTS)) u_result_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (slot_ready),
        .hold  (slot_in_burst[res_ptr]),
        .ptr   (res_ptr),
        .grant (rvalid)
    );

    // Read-channel select
    assign rid   = slot_rid[res_ptr];
    assign rdata = slot_rdata[res_ptr];
    assign rresp = slot_rresp[res_ptr];
    assign rlast = slot_rlast[res_ptr];    // Already low unless the beat is offered

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD = 4,    // 8 ns clock
    parameter int RST_CYCLES  = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released just after an edge, same as the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_axi_rd_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rd_slave;

    localparam int NUM_SLOTS = 4;
    localparam int FETCH_DLY = 24;
    localparam int TIMEOUT   = 4000;    // Cycles per wait loop
    localparam int NUM_RAND  = 40;

    logic clk;
    logic rst_n;

    // DUT ports
    axi_rd_pkg::id_t    arid;
    axi_rd_pkg::addr_t  araddr;
    axi_rd_pkg::len_t   arlen;
    axi_rd_pkg::size_t  arsize;
    axi_rd_pkg::burst_t arburst;
    logic               arvalid;
    logic               arready;
    axi_rd_pkg::id_t    rid;
    axi_rd_pkg::data_t  rdata;
    axi_rd_pkg::resp_t  rresp;
    logic               rlast;
    logic               rvalid;
    logic               rready;

    // Request table, indexed by ID
    logic               known   [16];
    axi_rd_pkg::addr_t  q_addr  [16];
    axi_rd_pkg::len_t   q_len   [16];
    axi_rd_pkg::size_t  q_size  [16];
    axi_rd_pkg::burst_t q_burst [16];
    int                 beat_no [16];    // Beats already returned

    int                 n_out;           // Requests in flight
    int                 full_cycles;     // Cycles with every slot taken
    logic               open_burst;      // A burst has started but not ended
    axi_rd_pkg::id_t    open_id;
    logic               stall_prev;      // Last cycle had rvalid without rready
    axi_rd_pkg::id_t    prev_rid;
    axi_rd_pkg::data_t  prev_data;
    axi_rd_pkg::resp_t  prev_resp;
    logic               prev_last;

    integer             seed;
    integer             bp_seed;
    logic               bp_en;           // Random rready on
    string              test_name;

    tb_clk_gen u_tb_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    axi_rd_slave #(
        .NUM_SLOTS (NUM_SLOTS),
        .FETCH_DLY (FETCH_DLY)
    ) u_axi_rd_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    // ------------------------------------------------------------------------
    // Reference model and checks
    // ------------------------------------------------------------------------
    // Expected beat n of a request, straight from the AXI burst rules
    function automatic void ref_beat(
        input  axi_rd_pkg::id_t    id,
        input  axi_rd_pkg::addr_t  start,
        input  axi_rd_pkg::len_t   len,
        input  axi_rd_pkg::size_t  size,
        input  axi_rd_pkg::burst_t burst,
        input  int                 n,
        output axi_rd_pkg::data_t  data,
        output axi_rd_pkg::resp_t  resp,
        output logic               last
    );
        int bytes;
        int win;
        int base;
        int a;
        bytes = 1 << size;
        case (burst)
            axi_rd_pkg::BURST_FIXED: begin
                a = int'(start);
            end
            axi_rd_pkg::BURST_WRAP: begin
                win  = bytes * (int'(len) + 1);
                base = (int'(start) / win) * win;
                a    = base + ((int'(start) - base) + n * bytes) % win;
            end
            default: begin    // INCR, beat 0 may be unaligned
                a = (n == 0) ? int'(start) : (int'(start) / bytes) * bytes + n * bytes;
            end
        endcase
        data = {12'h000, id, axi_rd_pkg::addr_t'(a)};
        resp = (id == axi_rd_pkg::ERR_ID && n == int'(len)) ? axi_rd_pkg::RESP_SLVERR
                                                            : axi_rd_pkg::RESP_OKAY;
        last = (n == int'(len));
    endfunction

    task automatic die(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // One R handshake, looked up by rid
    task automatic check_beat();
        axi_rd_pkg::data_t exp_data;
        axi_rd_pkg::resp_t exp_resp;
        logic              exp_last;
        int                n;
        if (open_burst) begin
            check_val("rid inside an open burst", 32'(open_id), 32'(rid));
        end
        n = beat_no[rid];
        ref_beat(rid, q_addr[rid], q_len[rid], q_size[rid], q_burst[rid], n,
                 exp_data, exp_resp, exp_last);
        check_val("rdata", exp_data, rdata);
        check_val("rresp", 32'(exp_resp), 32'(rresp));
        check_val("rlast", 32'(exp_last), 32'(rlast));
        beat_no[rid] = n + 1;
        if (rlast) begin
            known[rid] = 1'b0;    // ID free for reuse
            n_out--;
            open_burst = 1'b0;
        end else begin
            open_burst = 1'b1;
            open_id    = rid;
        end
    endtask

    task automatic record_req();
        if (known[arid]) begin
            die("an AR request reused an ID that was still in flight");
        end
        known[arid]   = 1'b1;
        q_addr[arid]  = araddr;
        q_len[arid]   = arlen;
        q_size[arid]  = arsize;
        q_burst[arid] = arburst;
        beat_no[arid] = 0;
        n_out++;
        if (n_out > NUM_SLOTS) begin
            die("more requests were accepted than slots, with no burst completed");
        end
    endtask

    // Sampled mid-cycle, values here are those of the next rising edge
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                known[i]   = 1'b0;
                beat_no[i] = 0;
            end
            n_out       = 0;
            full_cycles = 0;
            open_burst  = 1'b0;
            stall_prev  = 1'b0;
            check_val("rvalid in reset", 32'(0), 32'(rvalid));
            check_val("rlast in reset", 32'(0), 32'(rlast));
            check_val("rresp in reset", 32'(0), 32'(rresp));
        end else begin
            if (stall_prev) begin    // R fields frozen under back-pressure
                check_val("rvalid held", 32'(1), 32'(rvalid));
                check_val("rid held", 32'(prev_rid), 32'(rid));
                check_val("rdata held", prev_data, rdata);
                check_val("rresp held", 32'(prev_resp), 32'(rresp));
                check_val("rlast held", 32'(prev_last), 32'(rlast));
            end
            if (n_out >= NUM_SLOTS) begin
                check_val("arready with all slots busy", 32'(0), 32'(arready));
                full_cycles++;
            end
            if (rvalid && !known[rid]) begin
                die("rvalid was raised for an ID with no request in flight");
            end
            if (rvalid && rready) begin
                check_beat();
            end
            if (arvalid && arready) begin
                record_req();
            end
            stall_prev = rvalid && !rready;
            prev_rid   = rid;
            prev_data  = rdata;
            prev_resp  = rresp;
            prev_last  = rlast;
        end
    end

    // ------------------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------------------
    initial begin
        rready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            rready = bp_en ? ($random(bp_seed) % 4 != 0) : 1'b1;    // About 3 in 4
        end
    end

    // Starts and ends 1 ns after a rising edge
    task automatic issue_req(
        input axi_rd_pkg::id_t    id,
        input axi_rd_pkg::addr_t  addr,
        input axi_rd_pkg::len_t   len,
        input axi_rd_pkg::size_t  size,
        input axi_rd_pkg::burst_t burst
    );
        logic taken;
        int   waited;
        arid    = id;
        araddr  = addr;
        arlen   = len;
        arsize  = size;
        arburst = burst;
        arvalid = 1'b1;
        taken   = 1'b0;
        for (waited = 0; waited < TIMEOUT && !taken; waited++) begin
            @(negedge clk);
            taken = arready;
            @(posedge clk);
            #1;
        end
        if (!taken) begin
            die("arready never rose for a pending AR request");
        end
        arvalid = 1'b0;
    endtask

    task automatic issue_random();
        logic [31:0]        r;
        axi_rd_pkg::id_t    id;
        axi_rd_pkg::burst_t burst;
        axi_rd_pkg::size_t  size;
        axi_rd_pkg::len_t   len;
        axi_rd_pkg::addr_t  addr;
        r     = $random(seed);
        burst = (r[1:0] == 2'd3) ? axi_rd_pkg::BURST_INCR : r[1:0];
        size  = (r[3:2] == 2'd3) ? 3'd2 : {1'b0, r[3:2]};
        addr  = r[31:16];
        if (burst == axi_rd_pkg::BURST_WRAP) begin
            len  = (8'd2 << (r[5:4] % 2'd3)) - 8'd1;                   // 1, 3 or 7
            addr = addr & ~((axi_rd_pkg::addr_t'(1) << size) - 16'd1); // Size aligned
        end else begin
            len = {5'd0, r[6:4]};
        end
        id = r[15:12];
        for (int k = 0; k < 16 && known[id]; k++) begin
            id = id + 4'd1;    // Next ID not in flight
        end
        issue_req(id, addr, len, size, burst);
    endtask

    task automatic wait_idle();
        int waited;
        for (waited = 0; waited < TIMEOUT && n_out != 0; waited++) begin
            @(posedge clk);
            #1;
        end
        if (n_out != 0) begin
            die("bursts were still outstanding at the timeout");
        end
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    initial begin
        int                waited;
        int                full_before;
        int                bytes;
        axi_rd_pkg::len_t  len;
        axi_rd_pkg::addr_t addr;
        seed      = 32'h83d5_cb4b;
        bp_seed   = seed ^ 32'h0000_5a5a;    // Separate stream for rready
        bp_en     = 1'b0;
        test_name = "reset";
        arid      = '0;
        araddr    = '0;
        arlen     = '0;
        arsize    = '0;
        arburst   = '0;
        arvalid   = 1'b0;
        for (waited = 0; waited < 20 && rst_n !== 1'b1; waited++) begin
            @(negedge clk);
        end
        if (rst_n !== 1'b1) begin
            die("reset was never released");
        end
        @(posedge clk);
        #1;

        // Single INCR bursts, unaligned start
        test_name = "incr";
        for (int s = 0; s < 3; s++) begin
            for (int l = 0; l < 8; l++) begin
                addr = axi_rd_pkg::addr_t'(16'h1000 + l * 16'h0100 + s + 1);
                issue_req(axi_rd_pkg::id_t'((s * 8 + l) % 15), addr,
                          axi_rd_pkg::len_t'(l), axi_rd_pkg::size_t'(s), axi_rd_pkg::BURST_INCR);
                wait_idle();
            end
        end

        test_name = "fixed";
        issue_req(4'd3, 16'h3456, 8'd3, 3'd1, axi_rd_pkg::BURST_FIXED);
        wait_idle();
        issue_req(4'd4, 16'h0011, 8'd5, 3'd0, axi_rd_pkg::BURST_FIXED);
        wait_idle();

        // WRAP from the middle of the window
        test_name = "wrap";
        for (int s = 0; s < 3; s++) begin
            for (int w = 0; w < 3; w++) begin
                bytes = 1 << s;
                len   = axi_rd_pkg::len_t'((2 << w) - 1);
                addr  = axi_rd_pkg::addr_t'(16'h2000 + bytes * ((int'(len) + 1) / 2));
                issue_req(axi_rd_pkg::id_t'(s * 3 + w), addr, len,
                          axi_rd_pkg::size_t'(s), axi_rd_pkg::BURST_WRAP);
                wait_idle();
            end
        end

        test_name = "slverr";
        issue_req(4'd15, 16'h4000, 8'd3, 3'd2, axi_rd_pkg::BURST_INCR);
        wait_idle();
        issue_req(4'd15, 16'h4101, 8'd0, 3'd0, axi_rd_pkg::BURST_INCR);
        wait_idle();
        issue_req(4'd15, 16'h4204, 8'd7, 3'd1, axi_rd_pkg::BURST_WRAP);
        wait_idle();

        // Fifth request has to wait for a slot
        test_name   = "five_back_to_back";
        full_before = full_cycles;
        for (int i = 1; i <= 5; i++) begin
            issue_req(axi_rd_pkg::id_t'(i), axi_rd_pkg::addr_t'(16'h5000 + i * 16'h0100),
                      8'd7, 3'd2, axi_rd_pkg::BURST_INCR);
        end
        wait_idle();
        check_val("all slots busy at some point", 32'(1), 32'(full_cycles > full_before));

        test_name = "random";
        bp_en     = 1'b1;
        for (int i = 0; i < NUM_RAND; i++) begin
            issue_random();
        end
        wait_idle();
        bp_en = 1'b0;

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
axi_rd_pkg.sv
burst_addr_gen.sv
rr_slot_arbiter.sv
rd_slot.sv
axi_rd_slave.sv
tb_clk_gen.sv
tb_axi_rd_slave.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run the read-slave testbench
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_axi_rd_slave \
    -f compile.f -o tb_axi_rd_slave > build.log 2>&1 || { cat build.log; echo "BUILD FAILED"; exit 1; }
./obj_dir/tb_axi_rd_slave > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "RESULT: FAIL"; exit 1; }
echo "RESULT: PASS"
